// ==== dig_loop_assertions.sv ====
`default_nettype none

module dig_loop_assertions (
	input logic CKVD,
	input logic NRST,
	input logic pll_en,
	input logic dtc_en,
	input logic otw_cali_en,
	input logic [pll_word_pkg::MMD_S_W-1:0] mmd_s,
	input logic [pll_word_pkg::DTC_W-1:0] dcw,
	input logic [pll_cal_pkg::OTW_W-1:0] otw_p
);

	// only the five legal prescaler ranges
	a_mmd_s_legal: assert property (@(posedge CKVD) disable iff (!NRST)
		(mmd_s == 0 || mmd_s == 1 || mmd_s == 4 || mmd_s == 5 || mmd_s == 6))
		else $error("illegal prescaler select %0d", mmd_s);

	a_dcw_off: assert property (@(posedge CKVD) disable iff (!NRST)
		!(pll_en && dtc_en) |=> (dcw == '0))
		else $error("dtc word not parked");

	// calibration steps are 1 to 4 codes
	a_otw_step: assert property (@(posedge CKVD) disable iff (!NRST)
		(pll_en && otw_cali_en) |=> ((9'(otw_p - $past(otw_p)) <= 9'd4)
		|| (9'($past(otw_p) - otw_p) <= 9'd4)))
		else $error("tuning word jumped");

endmodule

bind dig_loop_top dig_loop_assertions i_chk (.*);

`default_nettype wire

// ==== dig_loop_testdata.txt ====
// kind fcw_int fcw_frac kdtc_init ka vctest step_sel otw_in opt exp_a exp_b
// kind 1 reset, 2 integer divider, 3 fractional, 4 dtc word, 5 gain cal, 6 otw cal
1 000 0000000 0123 00 0 0 0a0 0 032 4
2 00a 0000000 0100 00 0 0 100 0 00a 0
2 010 0000000 0100 00 0 0 100 0 010 0
2 011 0000000 0100 00 0 0 100 0 011 1
2 020 0000000 0100 00 0 0 100 0 020 1
2 021 0000000 0100 00 0 0 100 0 021 4
2 040 0000000 0100 00 0 0 100 0 040 4
2 041 0000000 0100 00 0 0 100 0 041 5
2 080 0000000 0100 00 0 0 100 0 080 5
2 081 0000000 0100 00 0 0 100 0 081 6
2 12c 0000000 0100 00 0 0 100 0 12c 6
3 028 1000000 0100 00 0 0 100 0 a10 2
3 028 1000000 0100 00 0 0 100 1 000 0
4 032 0000000 05dc 00 0 0 100 0 5dc 0
4 032 0000000 0abc 00 0 0 100 0 abc 0
5 032 0000000 0100 00 0 0 100 1 15d 164
5 032 0000000 07d0 00 0 0 100 0 76c 773
5 032 0000000 0100 1e 0 0 100 1 117 11b
6 032 0000000 0100 00 2 1 0a0 1 0a6 0a4

// ==== dig_loop_top.sv ====
`default_nettype none

module dig_loop_top (
	input  logic CKVD,
	input  logic NRST,
	input  logic pll_en,
	input  logic cfg_load,
	input  logic [pll_word_pkg::FCW_W-1:0] fcw,
	input  logic [pll_cal_pkg::KDTC_W-1:0] kdtc_init,
	input  logic [pll_cal_pkg::KA_W-1:0] ka,
	input  logic [pll_word_pkg::DN_WEIGHT_W-1:0] dn_weight,
	input  logic cal_mode,
	input  logic [pll_cal_pkg::OTW_W-1:0] otw_in,
	input  logic dsm_en,
	input  logic dn_en,
	input  logic mmd_en,
	input  logic dtc_en,
	input  logic gac_en,
	input  logic otw_cali_en,
	input  logic [1:0] otw_step_sel,
	input  logic phe_sig,   // spd
	input  logic phe_sig2,  // pfd
	input  logic [1:0] vctest,
	output logic [pll_word_pkg::MMD_P_W-1:0] mmd_p,
	output logic [pll_word_pkg::MMD_S_W-1:0] mmd_s,
	output logic [pll_word_pkg::DTC_W-1:0] dcw,
	output logic [pll_cal_pkg::KDTC_W-1:0] kdtc_int,
	output logic [pll_cal_pkg::OTW_W-1:0] otw_p,
	output logic [pll_cal_pkg::OTW_W-1:0] otw_n
);

	logic                                cfg_win_q;
	pll_word_pkg::fcw_word_t             fcw_q;
	logic [pll_cal_pkg::KDTC_W-1:0]      kdtc_init_q;
	logic [pll_cal_pkg::KA_W-1:0]        ka_q;
	logic [pll_word_pkg::DN_WEIGHT_W-1:0] dn_weight_q;
	logic                                cal_mode_q;
	logic [pll_cal_pkg::OTW_W-1:0]       otw_in_q;

	logic dsm_en_g, dn_en_g, mmd_en_g, dtc_en_g, gac_en_g, otw_en_g;
	logic signed [pll_word_pkg::CAR_W-1:0] dsm_car;
	logic [pll_word_pkg::PHE_W-1:0]        dsm_phe;
	logic [pll_cal_pkg::KDTC_W+pll_word_pkg::WF-1:0] kdtc;

	// --------------------
	// load window and shadows
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST)
			cfg_win_q <= 1'b1;  // first edge out of reset loads
		else
			cfg_win_q <= cfg_load;
	end

	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST || cfg_win_q) begin
			fcw_q.word  <= fcw;
			kdtc_init_q <= kdtc_init;
			ka_q        <= ka;
			dn_weight_q <= dn_weight;
			cal_mode_q  <= cal_mode;
			otw_in_q    <= otw_in;
		end
	end

	// master enable
	assign dsm_en_g = pll_en & dsm_en;
	assign dn_en_g  = pll_en & dn_en;
	assign mmd_en_g = pll_en & mmd_en;
	assign dtc_en_g = pll_en & dtc_en;
	assign gac_en_g = pll_en & gac_en;
	assign otw_en_g = pll_en & otw_cali_en;

	// --------------------
	mash11_dsm u_dsm (
		.CKVD(CKVD), .NRST(NRST), .en(dsm_en_g), .dn_en(dn_en_g), .dn_weight(dn_weight_q),
		.frac(fcw_q.f.frac), .car(dsm_car), .phe(dsm_phe)
	);

	mmd_ctrl u_mmd (
		.CKVD(CKVD), .NRST(NRST), .mmd_en(mmd_en_g), .fcw_int(fcw_q.f.int_part),
		.car(dsm_car), .mmd_p(mmd_p), .mmd_s(mmd_s)
	);

	dtc_ctrl u_dtc (
		.CKVD(CKVD), .NRST(NRST), .dtc_en(dtc_en_g), .kdtc(kdtc), .phe(dsm_phe), .dcw(dcw)
	);

	kdtc_gain_cal u_gac (
		.CKVD(CKVD), .NRST(NRST), .gac_en(gac_en_g), .cal_mode(cal_mode_q),
		.phe_sig(phe_sig), .phe_sig2(phe_sig2), .ka(ka_q), .kdtc_init(kdtc_init_q),
		.phe(dsm_phe), .kdtc(kdtc), .kdtc_int(kdtc_int)
	);

	otw_cali u_otw (
		.CKVD(CKVD), .NRST(NRST), .en(otw_en_g), .vctest(vctest),
		.step_sel(otw_step_sel), .otw_in(otw_in_q), .otw(otw_p)
	);

	assign otw_n = ~otw_p;  // complementary bank

endmodule

`default_nettype wire

// ==== dtc_ctrl.sv ====
`default_nettype none

module dtc_ctrl (
	input  logic CKVD,
	input  logic NRST,
	input  logic dtc_en,
	input  logic [pll_cal_pkg::KDTC_W+pll_word_pkg::WF-1:0] kdtc,
	input  logic [pll_word_pkg::PHE_W-1:0] phe,
	output logic [pll_word_pkg::DTC_W-1:0] dcw
);

	localparam int PROD_W = pll_cal_pkg::KDTC_W + pll_word_pkg::WF + pll_word_pkg::PHE_W;

	logic [PROD_W-1:0]                  prod_full;  // 2*WF fraction bits
	logic [PROD_W-pll_word_pkg::WF-1:0] prod_q;     // back to WF fraction bits
	logic [pll_word_pkg::DTC_W-1:0]     dcw_rnd;

	assign prod_full = kdtc * phe;

	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST)
			prod_q <= '0;
		else
			prod_q <= prod_full[PROD_W-1:pll_word_pkg::WF];
	end

	// round half up on the first fraction bit
	assign dcw_rnd = prod_q[pll_word_pkg::WF+pll_word_pkg::DTC_W-1:pll_word_pkg::WF]
		+ {{(pll_word_pkg::DTC_W-1){1'b0}}, prod_q[pll_word_pkg::WF-1]};

	// --------------------
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST)
			dcw <= '0;
		else if (dtc_en)
			dcw <= dcw_rnd;
		else
			dcw <= '0;  // dtc parked at zero delay
	end

endmodule

`default_nettype wire

// ==== files.f ====
pll_word_pkg.sv
pll_cal_pkg.sv
lfsr32.sv
mash11_dsm.sv
mmd_ctrl.sv
dtc_ctrl.sv
kdtc_gain_cal.sv
otw_cali.sv
dig_loop_top.sv
dig_loop_assertions.sv
tb_dig_loop.sv

// ==== kdtc_gain_cal.sv ====
`default_nettype none

module kdtc_gain_cal (
	input  logic CKVD,
	input  logic NRST,
	input  logic gac_en,
	input  logic cal_mode,  // 1: spd, 0: pfd
	input  logic phe_sig,
	input  logic phe_sig2,
	input  logic [pll_cal_pkg::KA_W-1:0] ka,
	input  logic [pll_cal_pkg::KDTC_W-1:0] kdtc_init,
	input  logic [pll_word_pkg::PHE_W-1:0] phe,
	output logic [pll_cal_pkg::KDTC_W+pll_word_pkg::WF-1:0] kdtc,
	output logic [pll_cal_pkg::KDTC_W-1:0] kdtc_int
);

	logic [pll_word_pkg::PHE_W-1:0] phe_dly [pll_cal_pkg::PHE_SYNC_DEPTH];
	logic                           sig_q;
	logic signed [pll_word_pkg::PHE_W:0] lms_err;  // one extra bit, phe reaches 2.0
	logic signed [pll_cal_pkg::KDTC_W+pll_word_pkg::WF-1:0] err_ext;
	logic signed [pll_cal_pkg::KDTC_W+pll_word_pkg::WF-1:0] step;
	logic [pll_cal_pkg::KA_W-1:0]   ka_mag;

	// --------------------
	// line phe up with the detector sign
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			for (int i = 0; i < pll_cal_pkg::PHE_SYNC_DEPTH; i++)
				phe_dly[i] <= '0;
			sig_q <= 1'b0;
		end else begin
			phe_dly[0] <= phe;
			for (int i = 1; i < pll_cal_pkg::PHE_SYNC_DEPTH; i++)
				phe_dly[i] <= phe_dly[i-1];
			sig_q <= cal_mode ? phe_sig : phe_sig2;
		end
	end

	// sig 1 means gain too small
	assign lms_err = sig_q ? $signed({1'b0, phe_dly[pll_cal_pkg::PHE_SYNC_DEPTH-1]})
		: -$signed({1'b0, phe_dly[pll_cal_pkg::PHE_SYNC_DEPTH-1]});
	assign ka_mag = ~ka + 1'b1;

	always_comb begin
		err_ext = lms_err;
		if (ka[pll_cal_pkg::KA_W-1])
			step = err_ext >>> ka_mag;  // mu below one
		else
			step = err_ext <<< ka;
	end

	// --------------------
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST)
			kdtc <= {kdtc_init, {pll_word_pkg::WF{1'b0}}};
		else if (gac_en)
			kdtc <= kdtc + $unsigned(step);
	end

	assign kdtc_int = kdtc[pll_cal_pkg::KDTC_W+pll_word_pkg::WF-1:pll_word_pkg::WF];

endmodule

`default_nettype wire

// ==== lfsr32.sv ====
`default_nettype none

module lfsr32 (
	input  logic CKVD,
	input  logic NRST,
	input  logic en,
	output logic dither
);

	logic [31:0] lfsr_q;
	logic        fb;

	// xnor taps 32, 22, 2, 1
	assign fb = ~(lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]);

	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			lfsr_q <= 32'd1;
		end else if (en) begin
			lfsr_q <= {lfsr_q[30:0], fb};
		end else begin
			lfsr_q <= 32'd1;  // parked at seed
		end
	end

	assign dither = en & lfsr_q[0];

endmodule

`default_nettype wire

// ==== mash11_dsm.sv ====
`default_nettype none

module mash11_dsm (
	input  logic CKVD,
	input  logic NRST,
	input  logic en,
	input  logic dn_en,
	input  logic [pll_word_pkg::DN_WEIGHT_W-1:0] dn_weight,
	input  logic [pll_word_pkg::WF-1:0] frac,
	output logic signed [pll_word_pkg::CAR_W-1:0] car,
	output logic [pll_word_pkg::PHE_W-1:0] phe
);

	logic                        dither;
	logic [pll_word_pkg::WF-1:0] dn_y;
	logic [pll_word_pkg::WF-1:0] dn_n;
	logic [pll_word_pkg::WF-1:0] dn_add;
	logic [pll_word_pkg::WF:0]   sum1_ext;  // carry on top
	logic [pll_word_pkg::WF:0]   sum2_ext;
	logic [pll_word_pkg::WF-1:0] sum1_q;
	logic [pll_word_pkg::WF-1:0] sum2_q;
	logic                        ca2_q;

	lfsr32 u_lfsr (
		.CKVD   (CKVD),
		.NRST   (NRST),
		.en     (dn_en),
		.dither (dither)
	);

	// dither adds 3 or 1 lsb-weights, the constant 1 is taken back out
	assign dn_y   = {{(pll_word_pkg::WF-2){1'b0}}, 2'b11} << dn_weight;
	assign dn_n   = {{(pll_word_pkg::WF-1){1'b0}}, 1'b1} << dn_weight;
	assign dn_add = dither ? (dn_y - dn_n) : '0;

	// --------------------
	// two cascaded accumulators
	assign sum1_ext = {1'b0, sum1_q} + {1'b0, frac} + {1'b0, dn_add};
	assign sum2_ext = {1'b0, sum2_q} + {1'b0, sum1_ext[pll_word_pkg::WF-1:0]};

	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			sum1_q <= '0;
			sum2_q <= '0;
			ca2_q  <= 1'b0;
		end else if (en) begin
			sum1_q <= sum1_ext[pll_word_pkg::WF-1:0];
			sum2_q <= sum2_ext[pll_word_pkg::WF-1:0];
			ca2_q  <= sum2_ext[pll_word_pkg::WF];
		end
	end

	// --------------------
	// noise cancelling combine, phe in (0, 2]
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			car <= '0;
			phe <= {2'b01, {pll_word_pkg::WF{1'b0}}};  // 1.0
		end else if (en) begin
			car <= {{(pll_word_pkg::CAR_W-1){1'b0}}, sum1_ext[pll_word_pkg::WF]}
				+ {{(pll_word_pkg::CAR_W-1){1'b0}}, sum2_ext[pll_word_pkg::WF]}
				- {{(pll_word_pkg::CAR_W-1){1'b0}}, ca2_q};
			phe <= {1'b0, sum2_ext[pll_word_pkg::WF], {pll_word_pkg::WF{1'b0}}}
				- {2'b00, sum1_ext[pll_word_pkg::WF-1:0]}
				+ {2'b01, {pll_word_pkg::WF{1'b0}}};
		end
	end

endmodule

`default_nettype wire

// ==== mmd_ctrl.sv ====
`default_nettype none

module mmd_ctrl (
	input  logic CKVD,
	input  logic NRST,
	input  logic mmd_en,
	input  logic [pll_word_pkg::WI-1:0] fcw_int,
	input  logic signed [pll_word_pkg::CAR_W-1:0] car,
	output logic [pll_word_pkg::MMD_P_W-1:0] mmd_p,
	output logic [pll_word_pkg::MMD_S_W-1:0] mmd_s
);

	logic [pll_word_pkg::WI-1:0]      fcw_int_q;
	logic [pll_word_pkg::WI-1:0]      car_ext;
	logic [pll_word_pkg::MMD_P_W-1:0] mmd_p_pre;

	assign car_ext = {{(pll_word_pkg::WI-pll_word_pkg::CAR_W){car[pll_word_pkg::CAR_W-1]}}, car};

	// integer -> sum -> output, 3 edges
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			fcw_int_q <= pll_word_pkg::MMD_P_RST;
			mmd_p_pre <= pll_word_pkg::MMD_P_RST;
			mmd_p     <= pll_word_pkg::MMD_P_RST;
		end else begin
			fcw_int_q <= fcw_int;
			mmd_p_pre <= mmd_en ? (fcw_int_q + car_ext) : fcw_int_q;
			mmd_p     <= mmd_p_pre;
		end
	end

	// --------------------
	// prescaler range from the integer part
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			mmd_s <= pll_word_pkg::MMD_S_RST;
		end else begin
			if (fcw_int_q <= 16)
				mmd_s <= 3'd0;
			else if (fcw_int_q <= 32)
				mmd_s <= 3'd1;
			else if (fcw_int_q <= 64)
				mmd_s <= 3'd4;
			else if (fcw_int_q <= 128)
				mmd_s <= 3'd5;
			else
				mmd_s <= 3'd6;
		end
	end

endmodule

`default_nettype wire

// ==== otw_cali.sv ====
`default_nettype none

module otw_cali (
	input  logic CKVD,
	input  logic NRST,
	input  logic en,
	input  logic [1:0] vctest,    // 10: vc high, 01: vc low
	input  logic [1:0] step_sel,  // step of 1 to 4
	input  logic [pll_cal_pkg::OTW_W-1:0] otw_in,
	output logic [pll_cal_pkg::OTW_W-1:0] otw
);

	logic [$clog2(pll_cal_pkg::OTW_WIN)-1:0] win_cnt;
	logic                                    win_end;
	logic                                    powerup;  // set once enabled
	logic [pll_cal_pkg::OTW_W-1:0]           step;

	assign step = {{(pll_cal_pkg::OTW_W-2){1'b0}}, step_sel} + 1'b1;

	// --------------------
	// monitor window
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			win_cnt <= '0;
			win_end <= 1'b0;
			powerup <= 1'b0;
		end else if (en) begin
			win_cnt <= win_cnt + 1'b1;
			win_end <= (win_cnt == pll_cal_pkg::OTW_WIN - 1);
			powerup <= 1'b1;
		end else begin
			win_cnt <= '0;
			win_end <= 1'b0;
		end
	end

	// --------------------
	// tuning word
	always_ff @(posedge CKVD or negedge NRST) begin
		if (!NRST) begin
			otw <= pll_cal_pkg::OTW_RST;
		end else if (en) begin
			if (win_end) begin
				case (vctest)
					2'b10:   otw <= otw + step;
					2'b01:   otw <= otw - step;
					default: otw <= otw;  // in range
				endcase
			end
		end else if (!powerup) begin
			otw <= otw_in;  // follow the programmed word until first use
		end
	end

endmodule

`default_nettype wire

// ==== pll_cal_pkg.sv ====
`default_nettype none

package pll_cal_pkg;

	// dtc gain loop
	localparam int KDTC_W         = 13;  // gain integer bits
	localparam int KA_W           = 5;   // signed step exponent, -16 to 15
	localparam int PHE_SYNC_DEPTH = 5;   // phe delay to line up with the sign

	// oscillator tuning word loop
	localparam int OTW_W = 9;
	localparam logic [OTW_W-1:0] OTW_RST = 9'd256;  // mid code
	localparam int OTW_WIN = 1024;  // cycles per monitor window

endpackage

`default_nettype wire

// ==== pll_word_pkg.sv ====
`default_nettype none

package pll_word_pkg;

	// --------------------
	// word widths
	localparam int WI          = 9;   // fcw integer part
	localparam int WF          = 26;  // fcw and phase fraction
	localparam int FCW_W       = WI + WF;
	localparam int PHE_W       = WF + 2;  // unsigned, two integer bits
	localparam int CAR_W       = 3;   // signed, -1 to 2
	localparam int MMD_P_W     = 9;
	localparam int MMD_S_W     = 3;
	localparam int DTC_W       = 12;
	localparam int DN_WEIGHT_W = 5;

	// --------------------
	// divider values after reset
	localparam logic [MMD_P_W-1:0] MMD_P_RST = 9'd50;
	localparam logic [MMD_S_W-1:0] MMD_S_RST = 3'b100;

	// fcw seen as a plain number or as int over frac
	typedef union packed {
		logic [FCW_W-1:0] word;
		struct packed {
			logic [WI-1:0] int_part;
			logic [WF-1:0] frac;
		} f;
	} fcw_word_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_dig_loop -f files.f \
	-o sim_dig_loop &&
./obj_dir/sim_dig_loop | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run passed" && exit 0 ||
{ echo "run failed"; exit 1; }

// ==== tb_dig_loop.sv ====
`default_nettype none

module tb_dig_loop;

	localparam int NCOL = 11;  // columns per data line
	localparam int MAXT = 32;
	localparam int NRAND = 6;

	logic CKVD;
	logic NRST;
	logic pll_en, cfg_load, cal_mode, dsm_en, dn_en, mmd_en;
	logic dtc_en, gac_en, otw_cali_en, phe_sig, phe_sig2;
	logic [pll_word_pkg::FCW_W-1:0] fcw;
	logic [pll_cal_pkg::KDTC_W-1:0] kdtc_init;
	logic [pll_cal_pkg::KA_W-1:0] ka;
	logic [pll_word_pkg::DN_WEIGHT_W-1:0] dn_weight;
	logic [pll_cal_pkg::OTW_W-1:0] otw_in;
	logic [1:0] otw_step_sel;
	logic [1:0] vctest;
	logic [pll_word_pkg::MMD_P_W-1:0] mmd_p;
	logic [pll_word_pkg::MMD_S_W-1:0] mmd_s;
	logic [pll_word_pkg::DTC_W-1:0] dcw;
	logic [pll_cal_pkg::KDTC_W-1:0] kdtc_int;
	logic [pll_cal_pkg::OTW_W-1:0] otw_p, otw_n;

	logic [31:0] tdata [NCOL*MAXT];
	int errors = 0;
	int failed = 0;
	int ntests = 0;
	int cycles = 0;
	int limit = 0;

	dig_loop_top i_dut (.*);

	initial begin
		CKVD = 1'b0;
		forever #50 CKVD = ~CKVD;
	end

	// run guard, armed once the test list is known
	always @(posedge CKVD) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles > limit) begin
			$display("timeout after %0d cycles, DUT did not finish the tests", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic note_error(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic reset_dut();
		NRST = 1'b0;
		repeat (5) @(negedge CKVD);
		NRST = 1'b1;
	endtask

	task automatic load_config();
		cfg_load = 1'b1;
		repeat (2) @(negedge CKVD);
		cfg_load = 1'b0;
	endtask

	// prescaler range by divider integer
	function automatic logic [2:0] presc_sel(input int n);
		if (n <= 16) return 3'd0;
		else if (n <= 32) return 3'd1;
		else if (n <= 64) return 3'd4;
		else if (n <= 128) return 3'd5;
		return 3'd6;
	endfunction

	function automatic int test_len(input logic [31:0] kind);
		case (kind)
			1: return 6;
			2: return 14;
			3: return 82;
			4: return 20;
			5: return 110;
			6: return 4140;
			default: return 0;
		endcase
	endfunction

	task automatic run_test(input logic [31:0] kind, input logic [31:0] fint,
		input logic [31:0] frac, input logic [31:0] kinit, input logic [31:0] ka_v,
		input logic [31:0] vct, input logic [31:0] ssel, input logic [31:0] otwin,
		input logic [31:0] opt, input logic [31:0] ea, input logic [31:0] eb);
		int err0;
		int sum;
		logic [pll_cal_pkg::KDTC_W-1:0] prev;
		logic [pll_cal_pkg::KDTC_W-1:0] d;
		logic [pll_cal_pkg::OTW_W-1:0] otw_inv;
		err0 = errors;
		sum = 0;
		pll_en = 1'b1;
		cfg_load = 1'b0;
		fcw = '0;  // word seen at reset differs from the test word
		kdtc_init = kinit[12:0];
		ka = ka_v[4:0];
		otw_in = otwin[8:0];
		otw_step_sel = ssel[1:0];
		vctest = vct[1:0];
		phe_sig = opt[0];
		{dsm_en, dn_en, mmd_en, dtc_en, gac_en, otw_cali_en} = '0;
		reset_dut();
		if (kind == 1) begin  // sampled before the first edge out of reset
			check_val("mmd_p", mmd_p, ea);
			check_val("mmd_s", mmd_s, eb);
			check_val("dcw", dcw, 0);
			check_val("kdtc_int", kdtc_int, kinit);
			check_val("otw_p", otw_p, pll_cal_pkg::OTW_RST);
		end else begin
			@(negedge CKVD);  // load window closed again
			fcw = {fint[8:0], frac[25:0]};
			load_config();
		end
		case (kind)
			2: begin
				{dsm_en, mmd_en, dtc_en, gac_en, otw_cali_en} = '1;
				repeat (4) @(negedge CKVD);
				check_val("mmd_p", mmd_p, ea);
				check_val("mmd_s", mmd_s, eb);
			end
			3: begin
				dsm_en = 1'b1;
				mmd_en = 1'b1;
				dn_en = opt[0];
				repeat (8) @(negedge CKVD);
				repeat (64) begin
					@(negedge CKVD);
					if (mmd_p + 1 < fint || mmd_p > fint + 2)
						note_error($sformatf("divider word %0d out of range for %0d", mmd_p, fint));
					sum += mmd_p;
				end
				if (!opt[0] && (sum > ea + eb || sum + eb < ea))
					note_error($sformatf("divider word sum %0d too far from %0d", sum, ea));
			end
			4: begin
				dsm_en = 1'b1;
				dtc_en = 1'b1;
				repeat (4) @(negedge CKVD);
				check_val("dcw", dcw, ea);
				pll_en = 1'b0;  // master enable gates the dtc too
				repeat (2) @(negedge CKVD);
				check_val("dcw", dcw, 0);
				pll_en = 1'b1;
				repeat (2) @(negedge CKVD);
				check_val("dcw", dcw, ea);
				dtc_en = 1'b0;
				repeat (2) @(negedge CKVD);
				check_val("dcw", dcw, 0);
			end
			5: begin
				dsm_en = 1'b1;
				gac_en = 1'b1;
				prev = kdtc_int;
				repeat (100) begin
					@(negedge CKVD);
					d = kdtc_int - prev;
					if (d != 0 && d != (opt[0] ? 13'd1 : 13'h1fff))
						note_error($sformatf("gain moved by 0x%0h in one cycle", d));
					prev = kdtc_int;
				end
				gac_en = 1'b0;
				if (kdtc_int < ea || kdtc_int > eb)
					note_error($sformatf("gain %0d outside %0d to %0d", kdtc_int, ea, eb));
			end
			6: begin
				repeat (3) @(negedge CKVD);
				check_val("otw_p", otw_p, otwin);
				otw_cali_en = 1'b1;
				repeat (3 * pll_cal_pkg::OTW_WIN + 8) @(negedge CKVD);
				check_val("otw_p", otw_p, ea);
				vctest = opt[1:0];
				repeat (pll_cal_pkg::OTW_WIN) @(negedge CKVD);
				check_val("otw_p", otw_p, eb);
				otw_cali_en = 1'b0;
				repeat (20) @(negedge CKVD);
				check_val("otw_p", otw_p, eb);
			end
			default: ;
		endcase
		// tuning word expected at the end of each kind
		if (kind == 1)
			otw_inv = ~pll_cal_pkg::OTW_RST;
		else if (kind == 6)
			otw_inv = ~eb[8:0];
		else
			otw_inv = ~otwin[8:0];
		check_val("otw_n", otw_n, otw_inv);
		ntests++;
		if (errors != err0)
			failed++;
		$display("test %0d kind %0d: %s", ntests, kind, (errors == err0) ? "ok" : "mismatch");
	endtask

	initial begin
		int total;
		int n;
		int r;
		void'($urandom(51));
		NRST = 1'b0;
		{pll_en, cfg_load, cal_mode, dsm_en, dn_en, mmd_en} = '0;
		{dtc_en, gac_en, otw_cali_en, phe_sig, phe_sig2} = '0;
		cal_mode = 1'b1;
		fcw = '0;
		kdtc_init = '0;
		ka = '0;
		dn_weight = 5'd20;
		otw_in = '0;
		otw_step_sel = '0;
		vctest = '0;
		for (int i = 0; i < NCOL * MAXT; i++)
			tdata[i] = '0;
		$readmemh("dig_loop_testdata.txt", tdata);
		n = 0;
		while (n < MAXT && tdata[n*NCOL] != 0)
			n++;
		total = 5 + NRAND * test_len(2);
		for (int i = 0; i < n; i++)
			total += test_len(tdata[i*NCOL]);
		limit = total + total / 4;
		reset_dut();
		for (int i = 0; i < n; i++)
			run_test(tdata[i*NCOL], tdata[i*NCOL+1], tdata[i*NCOL+2], tdata[i*NCOL+3],
				tdata[i*NCOL+4], tdata[i*NCOL+5], tdata[i*NCOL+6], tdata[i*NCOL+7],
				tdata[i*NCOL+8], tdata[i*NCOL+9], tdata[i*NCOL+10]);
		repeat (NRAND) begin
			r = $urandom % 512;
			run_test(2, r, 0, 'h100, 0, 0, 0, 'h100, 0, r, presc_sel(r));
		end
		$display("tests %0d, failed %0d, errors %0d", ntests, failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
